// File: design/dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// ============================================================================
// Bus widths
// ============================================================================
`define DMA_DATA_WIDTH      32
`define DMA_ADDR_WIDTH      32
`define DMA_AXI_LEN_WIDTH   8
`define DMA_BYTES_PER_BEAT  4

// INCR burst limit in beats
`define DMA_MAX_BURST       16

// ============================================================================
// Descriptor layout
// ============================================================================
`define DMA_DESC_WORDS      4
`define DMA_DESC_IDX_WIDTH  2
`define DMA_DESC_BYTES      16

// Word positions inside a descriptor, the last word is the unused control word
`define DMA_DESC_SRC_WORD   0
`define DMA_DESC_DST_WORD   1
`define DMA_DESC_LEN_WORD   2

`endif

// File: design/dma_axi_pkg.sv
`include "dma_defines.svh"

package dma_axi_pkg;

    // ========================================================================
    // AXI4 read channel types
    // ========================================================================

    // Response codes on the R channel
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Burst length field, beats minus one
    typedef logic [`DMA_AXI_LEN_WIDTH-1:0] axi_len_t;

    // Read request on the AR channel
    // Size is one word and burst type is INCR on every request
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] addr;
        axi_len_t                   len;
    } axi_ar_t;

    // One beat on the R channel
    typedef struct packed {
        logic [`DMA_DATA_WIDTH-1:0] data;
        axi_resp_e                  resp;
        logic                       last;
    } axi_r_t;

endpackage

// File: design/dma_ctrl_pkg.sv
`include "dma_defines.svh"

package dma_ctrl_pkg;

    // ========================================================================
    // Engine control types
    // ========================================================================

    // Job sequencing
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        FETCH_DESC = 3'd1,
        READ_SETUP = 3'd2,
        READ_DATA  = 3'd3,
        DONE       = 3'd4
    } dma_state_e;

    // Fields taken from the job descriptor
    // Length in bytes, always a multiple of the beat size
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] src;
        logic [`DMA_ADDR_WIDTH-1:0] dst;
        logic [`DMA_ADDR_WIDTH-1:0] length;
    } dma_desc_t;

    // Write into the local tile memory
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] addr;
        logic [`DMA_DATA_WIDTH-1:0] data;
    } lmem_wr_t;

endpackage

// File: design/dma_fsm.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        desc_done,
    input  logic                        zero_len,
    input  logic                        last_burst,
    input  logic                        ar_accept,
    input  logic                        r_accept,
    input  dma_axi_pkg::axi_r_t         r,
    input  dma_axi_pkg::axi_ar_t        desc_req,
    input  dma_axi_pkg::axi_ar_t        burst_req,
    output dma_ctrl_pkg::dma_state_e    state,
    output logic                        rd_issue,
    output dma_axi_pkg::axi_ar_t        rd_req,
    output logic                        busy,
    output logic                        done,
    output logic                        error,
    output logic [`DMA_ADDR_WIDTH-1:0]  head_ptr
);
    import dma_axi_pkg::*;
    import dma_ctrl_pkg::*;

    dma_state_e state_next;
    logic       rd_pending;

    // ========================================================================
    // Job sequencing
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = FETCH_DESC;
                end
            end
            FETCH_DESC: begin
                if (desc_done) begin
                    state_next = zero_len ? DONE : READ_SETUP;
                end
            end
            READ_SETUP: begin
                if (ar_accept) begin
                    state_next = READ_DATA;
                end
            end
            READ_DATA: begin
                if (r_accept && r.last) begin
                    state_next = last_burst ? DONE : READ_SETUP;
                end
            end
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // ========================================================================
    // Read request selection
    // ========================================================================

    // One request in flight, released by its final beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else if (rd_issue) begin
            rd_pending <= 1'b1;
        end else if (r_accept && (r.last || state == FETCH_DESC)) begin
            rd_pending <= 1'b0;
        end
    end

    assign rd_issue = !rd_pending &&
                      ((state == FETCH_DESC && !desc_done) || state == READ_SETUP);
    assign rd_req   = (state == READ_SETUP) ? burst_req : desc_req;

    // Status registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            error    <= 1'b0;
            head_ptr <= '0;
        end else begin
            busy <= (state != IDLE);
            done <= (state == DONE);
            // Sticky until the next job is started
            if (r_accept && r.resp != OKAY) begin
                error <= 1'b1;
            end else if (start && state == IDLE) begin
                error <= 1'b0;
            end
            if (state == DONE) begin
                head_ptr <= head_ptr + `DMA_DESC_BYTES;
            end
        end
    end

endmodule

// File: design/dma_desc_fetch.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_desc_fetch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  dma_ctrl_pkg::dma_state_e    state,
    input  logic [`DMA_ADDR_WIDTH-1:0]  job_desc_addr,
    input  logic                        ar_accept,
    input  logic                        r_accept,
    input  dma_axi_pkg::axi_r_t         r,
    output dma_axi_pkg::axi_ar_t        desc_req,
    output logic                        desc_done,
    output dma_ctrl_pkg::dma_desc_t     desc
);
    import dma_ctrl_pkg::*;

    logic [`DMA_DESC_IDX_WIDTH-1:0] word_idx;
    logic                           beat_wait;
    logic                           all_words;
    logic [`DMA_ADDR_WIDTH-1:0]     base_addr;

    // Job address is held from the doorbell cycle
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            base_addr <= job_desc_addr;
        end
    end

    // ========================================================================
    // Word index and outstanding beat
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_idx  <= '0;
            beat_wait <= 1'b0;
            all_words <= 1'b0;
        end else if (state == IDLE) begin
            word_idx  <= '0;
            beat_wait <= 1'b0;
            all_words <= 1'b0;
        end else if (state == FETCH_DESC) begin
            if (ar_accept) begin
                beat_wait <= 1'b1;
            end else if (r_accept && beat_wait) begin
                beat_wait <= 1'b0;
                word_idx  <= word_idx + 1'b1;
                if (word_idx == `DMA_DESC_WORDS - 1) begin
                    all_words <= 1'b1;
                end
            end
        end
    end

    // Each word goes straight to its field, control word dropped
    always_ff @(posedge clk) begin
        if (state == FETCH_DESC && r_accept && beat_wait) begin
            case (word_idx)
                `DMA_DESC_SRC_WORD: desc.src    <= r.data;
                `DMA_DESC_DST_WORD: desc.dst    <= r.data;
                `DMA_DESC_LEN_WORD: desc.length <= r.data;
                default: ;
            endcase
        end
    end

    // Single beat at job address plus word offset
    assign desc_req.addr = base_addr + word_idx * `DMA_BYTES_PER_BEAT;
    assign desc_req.len  = '0;

    assign desc_done = all_words && (state == FETCH_DESC);

endmodule

// File: design/dma_burst_counter.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_burst_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  dma_ctrl_pkg::dma_state_e    state,
    input  logic                        desc_done,
    input  dma_ctrl_pkg::dma_desc_t     desc,
    input  logic                        r_accept,
    output dma_axi_pkg::axi_ar_t        burst_req,
    output logic [`DMA_ADDR_WIDTH-1:0]  beat_addr,
    output logic                        last_burst,
    output logic                        zero_len
);
    import dma_axi_pkg::*;
    import dma_ctrl_pkg::*;

    logic [`DMA_ADDR_WIDTH-1:0] src_addr;
    logic [`DMA_ADDR_WIDTH-1:0] dst_addr;
    logic [`DMA_ADDR_WIDTH-1:0] remaining;
    logic [`DMA_ADDR_WIDTH-1:0] burst_bytes;
    axi_len_t                   burst_beats;
    axi_len_t                   burst_len;
    axi_len_t                   beat_cnt;
    logic                       burst_end;

    // ========================================================================
    // Next burst size
    // ========================================================================
    always_comb begin
        if (remaining >= `DMA_MAX_BURST * `DMA_BYTES_PER_BEAT) begin
            burst_beats = axi_len_t'(`DMA_MAX_BURST);
        end else begin
            burst_beats = axi_len_t'(remaining / `DMA_BYTES_PER_BEAT);
        end
    end

    assign burst_len   = burst_beats - 1'b1;
    assign burst_bytes = burst_beats * `DMA_BYTES_PER_BEAT;
    assign burst_end   = (state == READ_DATA) && r_accept && (beat_cnt == burst_len);

    // ========================================================================
    // Counters
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= '0;
            beat_cnt  <= '0;
        end else if (desc_done) begin
            remaining <= desc.length;
            beat_cnt  <= '0;
        end else if (burst_end) begin
            remaining <= remaining - burst_bytes;
            beat_cnt  <= '0;
        end else if (state == READ_DATA && r_accept) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Both addresses step together by the finished burst
    always_ff @(posedge clk) begin
        if (desc_done) begin
            src_addr <= desc.src;
            dst_addr <= desc.dst;
        end else if (burst_end) begin
            src_addr <= src_addr + burst_bytes;
            dst_addr <= dst_addr + burst_bytes;
        end
    end

    assign burst_req.addr = src_addr;
    assign burst_req.len  = burst_len;

    // Local address of the beat now on the R channel
    assign beat_addr = dst_addr + beat_cnt * `DMA_BYTES_PER_BEAT;

    assign last_burst = (remaining - burst_bytes) == '0;
    assign zero_len   = (desc.length == '0);

endmodule

// File: design/dma_read_port.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_read_port (
    input  logic                        clk,
    input  logic                        rst_n,
    input  dma_ctrl_pkg::dma_state_e    state,
    input  logic                        rd_issue,
    input  dma_axi_pkg::axi_ar_t        rd_req,
    input  logic [`DMA_ADDR_WIDTH-1:0]  beat_addr,
    input  logic                        arready,
    input  logic                        rvalid,
    input  dma_axi_pkg::axi_r_t         r,
    output dma_axi_pkg::axi_ar_t        ar,
    output logic                        arvalid,
    output logic                        rready,
    output logic                        ar_accept,
    output logic                        r_accept,
    output dma_ctrl_pkg::lmem_wr_t      lmem_wr,
    output logic                        lmem_we
);
    import dma_ctrl_pkg::*;

    logic desc_beat_wait;

    // ========================================================================
    // AR channel
    // ========================================================================

    // Request held stable until the slave takes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (rd_issue) begin
            arvalid <= 1'b1;
        end else if (ar_accept) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            ar <= rd_req;
        end
    end

    assign ar_accept = arvalid && arready;

    // ========================================================================
    // R channel
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            desc_beat_wait <= 1'b0;
        end else if (ar_accept && state == FETCH_DESC) begin
            desc_beat_wait <= 1'b1;
        end else if (r_accept) begin
            desc_beat_wait <= 1'b0;
        end
    end

    assign rready   = (state == READ_DATA) || (state == FETCH_DESC && desc_beat_wait);
    assign r_accept = rvalid && rready;

    // Local memory write, data beats only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lmem_we <= 1'b0;
        end else begin
            lmem_we <= r_accept && (state == READ_DATA);
        end
    end

    always_ff @(posedge clk) begin
        if (r_accept && state == READ_DATA) begin
            lmem_wr.addr <= beat_addr;
            lmem_wr.data <= r.data;
        end
    end

endmodule

// File: design/dma_engine_top.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_engine_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // Doorbell and status
    input  logic                        start,
    input  logic [`DMA_ADDR_WIDTH-1:0]  job_desc_addr,
    output logic                        busy,
    output logic                        done,
    output logic                        error,
    output logic [`DMA_ADDR_WIDTH-1:0]  head_ptr,

    // AXI4 read address
    output dma_axi_pkg::axi_ar_t        ar,
    output logic                        arvalid,
    input  logic                        arready,

    // AXI4 read data
    input  dma_axi_pkg::axi_r_t         r,
    input  logic                        rvalid,
    output logic                        rready,

    // Tile memory write port
    output dma_ctrl_pkg::lmem_wr_t      lmem_wr,
    output logic                        lmem_we
);
    import dma_axi_pkg::*;
    import dma_ctrl_pkg::*;

    dma_state_e                 state;
    axi_ar_t                    desc_req;
    axi_ar_t                    burst_req;
    axi_ar_t                    rd_req;
    dma_desc_t                  desc;
    logic                       desc_done;
    logic                       zero_len;
    logic                       last_burst;
    logic                       rd_issue;
    logic                       ar_accept;
    logic                       r_accept;
    logic [`DMA_ADDR_WIDTH-1:0] beat_addr;

    dma_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .desc_done  (desc_done),
        .zero_len   (zero_len),
        .last_burst (last_burst),
        .ar_accept  (ar_accept),
        .r_accept   (r_accept),
        .r          (r),
        .desc_req   (desc_req),
        .burst_req  (burst_req),
        .state      (state),
        .rd_issue   (rd_issue),
        .rd_req     (rd_req),
        .busy       (busy),
        .done       (done),
        .error      (error),
        .head_ptr   (head_ptr)
    );

    dma_desc_fetch u_desc_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .job_desc_addr (job_desc_addr),
        .ar_accept     (ar_accept),
        .r_accept      (r_accept),
        .r             (r),
        .desc_req      (desc_req),
        .desc_done     (desc_done),
        .desc          (desc)
    );

    dma_burst_counter u_burst_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .desc_done  (desc_done),
        .desc       (desc),
        .r_accept   (r_accept),
        .burst_req  (burst_req),
        .beat_addr  (beat_addr),
        .last_burst (last_burst),
        .zero_len   (zero_len)
    );

    dma_read_port u_read_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .rd_issue  (rd_issue),
        .rd_req    (rd_req),
        .beat_addr (beat_addr),
        .arready   (arready),
        .rvalid    (rvalid),
        .r         (r),
        .ar        (ar),
        .arvalid   (arvalid),
        .rready    (rready),
        .ar_accept (ar_accept),
        .r_accept  (r_accept),
        .lmem_wr   (lmem_wr),
        .lmem_we   (lmem_we)
    );

endmodule

// File: testbench/tb_ddr_model.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module tb_ddr_model #(
    parameter int unsigned MEM_WORDS = 1024,
    parameter logic [31:0] ERR_ADDR  = 32'h0000_0814
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dma_axi_pkg::axi_ar_t ar,
    input  logic                 arvalid,
    output logic                 arready,
    output dma_axi_pkg::axi_r_t  r,
    output logic                 rvalid,
    input  logic                 rready
);
    import dma_axi_pkg::*;

    logic [`DMA_DATA_WIDTH-1:0] mem [0:MEM_WORDS-1];
    logic [31:0]                rng_state;
    logic                       pending;
    logic                       beat_taken;
    logic [`DMA_ADDR_WIDTH-1:0] cur_addr;
    logic [8:0]                 beats_left;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Roughly one draw in four is a stall
    task automatic roll(output logic go);
        rng_state = xorshift32(rng_state);
        go = (rng_state[1:0] != 2'b00);
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
        mem[(addr >> 2) % MEM_WORDS] = data;
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return mem[(addr >> 2) % MEM_WORDS];
    endfunction

    // Handshakes seen at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            beat_taken <= 1'b0;
            cur_addr   <= '0;
            beats_left <= '0;
        end else begin
            beat_taken <= rvalid && rready;
            if (arvalid && arready) begin
                pending    <= 1'b1;
                cur_addr   <= ar.addr;
                beats_left <= {1'b0, ar.len} + 9'd1;
            end else if (rvalid && rready) begin
                cur_addr   <= cur_addr + `DMA_BYTES_PER_BEAT;
                beats_left <= beats_left - 9'd1;
                if (beats_left == 9'd1) begin
                    pending <= 1'b0;
                end
            end
        end
    end

    // ========================================================================
    // Memory fill and channel driver, outputs change on the falling edge
    // ========================================================================
    initial begin
        logic go;
        rng_state = 32'd6;
        arready   = 1'b0;
        rvalid    = 1'b0;
        r         = '0;
        // Pattern covers every bit of the word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[15:0] ^ 16'h5a3c, ~i[15:0]};
        end
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                arready = 1'b0;
                rvalid  = 1'b0;
                r       = '0;
            end else begin
                roll(go);
                arready = !pending && go;
                // A presented beat stays put until it is taken
                if (!rvalid || beat_taken) begin
                    roll(go);
                    if (pending && go) begin
                        rvalid = 1'b1;
                        r.data = read_word(cur_addr);
                        r.resp = (cur_addr == ERR_ADDR) ? SLVERR : OKAY;
                        r.last = (beats_left == 9'd1);
                    end else begin
                        rvalid = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: testbench/tb_dma_engine.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module tb_dma_engine;
    import dma_axi_pkg::*;
    import dma_ctrl_pkg::*;

    localparam logic [31:0] ERR_ADDR   = 32'h0000_0814;
    localparam int          JOB_CYCLES = 2000;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic [`DMA_ADDR_WIDTH-1:0] job_desc_addr;
    logic                       busy;
    logic                       done;
    logic                       error;
    logic [`DMA_ADDR_WIDTH-1:0] head_ptr;
    axi_ar_t                    ar;
    logic                       arvalid;
    logic                       arready;
    axi_r_t                     r;
    logic                       rvalid;
    logic                       rready;
    lmem_wr_t                   lmem_wr;
    logic                       lmem_we;

    // Expected traffic that each job queues and the monitor drains
    logic [31:0] exp_ar_addr [$];
    logic [7:0]  exp_ar_len  [$];
    logic [31:0] exp_wr_addr [$];
    logic [31:0] exp_wr_data [$];
    logic [31:0] exp_head;
    logic        exp_error;

    logic    prev_arvalid;
    logic    prev_arready;
    logic    prev_done;
    logic    prev_error;
    logic    prev_start;
    axi_ar_t prev_ar;
    logic    rd_outstanding;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    dma_engine_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .job_desc_addr (job_desc_addr),
        .busy          (busy),
        .done          (done),
        .error         (error),
        .head_ptr      (head_ptr),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .lmem_wr       (lmem_wr),
        .lmem_we       (lmem_we)
    );

    tb_ddr_model #(.ERR_ADDR(ERR_ADDR)) ddr (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("mismatch at %0t: %s expected %h actual %h",
                            $time, name, expected, actual));
    endtask

    // ========================================================================
    // Bus monitor on the rising edge
    // ========================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            prev_arvalid   = 1'b0;
            prev_arready   = 1'b0;
            prev_done      = 1'b0;
            prev_error     = 1'b0;
            prev_start     = 1'b0;
            prev_ar        = '0;
            rd_outstanding = 1'b0;
        end else begin
            // Beats are taken only while a request is outstanding
            assert (rready == rd_outstanding)
                else report_mismatch("rready", rd_outstanding, rready);
            // A waiting request must not move
            if (prev_arvalid && !prev_arready) begin
                assert (arvalid) else abort_run("arvalid dropped before arready");
                assert (ar.addr == prev_ar.addr)
                    else report_mismatch("ar.addr", prev_ar.addr, ar.addr);
                assert (ar.len == prev_ar.len)
                    else report_mismatch("ar.len", prev_ar.len, ar.len);
            end
            if (rvalid && rready && r.last) begin
                rd_outstanding = 1'b0;
            end
            if (arvalid && arready) begin
                assert (exp_ar_addr.size() != 0) else abort_run("unexpected read request");
                assert (ar.addr == exp_ar_addr[0])
                    else report_mismatch("ar.addr", exp_ar_addr[0], ar.addr);
                assert (ar.len == exp_ar_len[0])
                    else report_mismatch("ar.len", exp_ar_len[0], ar.len);
                void'(exp_ar_addr.pop_front());
                void'(exp_ar_len.pop_front());
                rd_outstanding = 1'b1;
            end
            if (lmem_we) begin
                assert (exp_wr_addr.size() != 0) else abort_run("unexpected local write");
                assert (lmem_wr.addr == exp_wr_addr[0])
                    else report_mismatch("lmem_wr.addr", exp_wr_addr[0], lmem_wr.addr);
                assert (lmem_wr.data == exp_wr_data[0])
                    else report_mismatch("lmem_wr.data", exp_wr_data[0], lmem_wr.data);
                void'(exp_wr_addr.pop_front());
                void'(exp_wr_data.pop_front());
            end
            if (done) begin
                assert (!prev_done) else abort_run("done stayed high for a second cycle");
                assert (head_ptr == exp_head) else report_mismatch("head_ptr", exp_head, head_ptr);
                assert (error == exp_error) else report_mismatch("error", exp_error, error);
                assert (exp_ar_addr.size() == 0) else abort_run("job ended with reads missing");
                assert (exp_wr_addr.size() == 0) else abort_run("job ended with writes missing");
            end
            if (prev_done) begin
                assert (!busy) else report_mismatch("busy", 0, busy);
            end
            // Error is sticky until a doorbell
            if (prev_error && !error) begin
                assert (prev_start) else abort_run("error cleared without a new start");
            end
            prev_arvalid = arvalid;
            prev_arready = arready;
            prev_done    = done;
            prev_error   = error;
            prev_start   = start;
            prev_ar      = ar;
        end
    end

    task automatic check_reset_values();
        assert (busy == 1'b0) else report_mismatch("busy", 0, busy);
        assert (done == 1'b0) else report_mismatch("done", 0, done);
        assert (error == 1'b0) else report_mismatch("error", 0, error);
        assert (arvalid == 1'b0) else report_mismatch("arvalid", 0, arvalid);
        assert (lmem_we == 1'b0) else report_mismatch("lmem_we", 0, lmem_we);
        assert (head_ptr == '0) else report_mismatch("head_ptr", 0, head_ptr);
    endtask

    // Word 3 holds a direction bit that the engine ignores
    task automatic write_descriptor(input logic [31:0] desc_addr, input logic [31:0] src,
                                    input logic [31:0] dst, input logic [31:0] len);
        ddr.store_word(desc_addr, src);
        ddr.store_word(desc_addr + 4, dst);
        ddr.store_word(desc_addr + 8, len);
        ddr.store_word(desc_addr + 12, 32'h0000_0001);
    endtask

    // ========================================================================
    // One job from doorbell to done
    // ========================================================================
    task automatic run_job(input logic [31:0] desc_addr, input logic [31:0] src,
                           input logic [31:0] dst, input logic [31:0] len);
        logic [31:0] addr;
        logic [31:0] left;
        logic [31:0] beats;
        int          cycles;
        for (int w = 0; w < `DMA_DESC_WORDS; w++) begin
            exp_ar_addr.push_back(desc_addr + w * 4);
            exp_ar_len.push_back(8'd0);
        end
        addr = src;
        left = len;
        while (left != 0) begin
            beats = (left >= 64) ? 32'd16 : left / 4;
            exp_ar_addr.push_back(addr);
            exp_ar_len.push_back(beats[7:0] - 8'd1);
            addr = addr + beats * 4;
            left = left - beats * 4;
        end
        for (int i = 0; i < len / 4; i++) begin
            exp_wr_addr.push_back(dst + i * 4);
            exp_wr_data.push_back(ddr.read_word(src + i * 4));
        end
        exp_head  = exp_head + 16;
        exp_error = (ERR_ADDR >= src) && (ERR_ADDR < src + len);

        @(negedge clk);
        start         = 1'b1;
        job_desc_addr = desc_addr;
        @(negedge clk);
        start = 1'b0;
        assert (!busy) else report_mismatch("busy", 0, busy);
        assert (!error) else report_mismatch("error", 0, error);
        @(negedge clk);
        assert (busy) else report_mismatch("busy", 1, busy);

        cycles = 0;
        while (!done && cycles < JOB_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        assert (done) else abort_run("timeout waiting for done");
        @(negedge clk);
        assert (!busy) else report_mismatch("busy", 0, busy);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        rst_n         = 1'b0;
        start         = 1'b0;
        job_desc_addr = '0;
        exp_head      = '0;
        exp_error     = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_values();

        write_descriptor(32'h000, 32'h400, 32'h1000, 32'd100);
        write_descriptor(32'h010, 32'h500, 32'h2000, 32'd64);
        write_descriptor(32'h020, 32'h600, 32'h3000, 32'd0);
        write_descriptor(32'h030, 32'h800, 32'h4000, 32'd32);

        run_job(32'h000, 32'h400, 32'h1000, 32'd100);
        run_job(32'h010, 32'h500, 32'h2000, 32'd64);
        run_job(32'h020, 32'h600, 32'h3000, 32'd0);
        run_job(32'h030, 32'h800, 32'h4000, 32'd32);
        // Short job after the faulty one shows the flag clearing
        run_job(32'h020, 32'h600, 32'h3000, 32'd0);

        repeat (2) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/dma_axi_pkg.sv
design/dma_ctrl_pkg.sv
design/dma_fsm.sv
design/dma_desc_fetch.sv
design/dma_burst_counter.sv
design/dma_read_port.sv
design/dma_engine_top.sv
testbench/tb_ddr_model.sv
testbench/tb_dma_engine.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_dma_engine -o sim_dma_engine

sim_out=$(./obj_dir/sim_dma_engine 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
